// ==== Bender.yml ====
package:
  name: rammodel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/rammodel_pkg.sv
      - logic/rv_fork.sv
      - logic/rammodel_timing.sv
      - logic/rammodel_txn_gate.sv
      - logic/rammodel_store.sv
      - logic/rammodel_simple.sv
      - logic/rammodel_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_rammodel.sv

// ==== include/rammodel_defines.svh ====
`ifndef RAMMODEL_DEFINES_SVH
`define RAMMODEL_DEFINES_SVH

// Channel widths
`define RAM_ADDR_WIDTH     8
`define RAM_DATA_WIDTH     32
`define RAM_ID_WIDTH       4
`define RAM_LEN_WIDTH      4      // Beats minus one

// Latencies seen by the DUT
`define RAM_READ_LATENCY   6      // AR accept to first R due
`define RAM_WRITE_LATENCY  4      // Last W accept to B due

// Backing store depth in words
`define RAM_WORDS          256

`endif

// ==== logic/rammodel_pkg.sv ====
`default_nettype none

`include "rammodel_defines.svh"

package rammodel_pkg;

    typedef struct packed {
        logic [`RAM_ID_WIDTH-1:0]   id;
        logic [`RAM_ADDR_WIDTH-1:0] addr;     // Word address
        logic [`RAM_LEN_WIDTH-1:0]  len;
    } ax_t;

    typedef struct packed {
        logic [`RAM_DATA_WIDTH-1:0] data;
        logic                       last;
    } w_t;

    typedef struct packed {
        logic [`RAM_ID_WIDTH-1:0]   id;
        logic [`RAM_DATA_WIDTH-1:0] data;
        logic                       last;
    } r_t;

    typedef struct packed {
        logic [`RAM_ID_WIDTH-1:0]   id;
    } b_t;

    typedef enum logic [1:0] {UP, DRAIN, DOWN} gate_state_t;

endpackage

`default_nettype wire

// ==== logic/rammodel_simple.sv ====
`timescale 1ns/1ns
`default_nettype none

module rammodel_simple import rammodel_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ar_valid,
    output logic ar_ready,
    input  ax_t  ar_payload,
    input  logic aw_valid,
    output logic aw_ready,
    input  ax_t  aw_payload,
    input  logic w_valid,
    output logic w_ready,
    input  w_t   w_payload,
    output logic r_valid,
    input  logic r_ready,
    output r_t   r_payload,
    output logic b_valid,
    input  logic b_ready,
    output b_t   b_payload,
    input  logic pause,
    input  logic up_req,
    input  logic down_req,
    output logic up,
    output logic down,
    output logic dut_stall,
    output logic mem_ar_valid,
    input  logic mem_ar_ready,
    output ax_t  mem_ar_payload,
    output logic mem_aw_valid,
    input  logic mem_aw_ready,
    output ax_t  mem_aw_payload,
    output logic mem_w_valid,
    input  logic mem_w_ready,
    output w_t   mem_w_payload,
    input  logic mem_r_valid,
    output logic mem_r_ready,
    input  r_t   mem_r_payload,
    input  logic mem_b_valid,
    output logic mem_b_ready,
    input  b_t   mem_b_payload
);
    logic tim_ar_valid;
    logic tim_ar_ready;
    ax_t  tim_ar_payload;
    logic tim_aw_valid;
    logic tim_aw_ready;
    logic tim_w_valid;
    logic tim_w_ready;
    w_t   tim_w_payload;
    logic tim_r_valid;
    logic tim_b_valid;
    logic dat_ar_valid;
    logic dat_ar_ready;
    ax_t  dat_ar_payload;
    logic dat_aw_valid;
    logic dat_aw_ready;
    ax_t  dat_aw_payload;
    logic dat_w_valid;
    logic dat_w_ready;
    w_t   dat_w_payload;
    logic dat_r_valid;
    logic dat_r_ready;
    logic dat_b_valid;
    logic dat_b_ready;

    rv_fork #(.payload_t(ax_t)) u_fork_ar (
        .clk        (clk),
        .rst        (rst),
        .s_valid    (ar_valid),
        .s_ready    (ar_ready),
        .s_payload  (ar_payload),
        .m1_valid   (tim_ar_valid),
        .m1_ready   (tim_ar_ready),
        .m1_payload (tim_ar_payload),
        .m2_valid   (dat_ar_valid),
        .m2_ready   (dat_ar_ready),
        .m2_payload (dat_ar_payload)
    );

    rv_fork #(.payload_t(ax_t)) u_fork_aw (
        .clk        (clk),
        .rst        (rst),
        .s_valid    (aw_valid),
        .s_ready    (aw_ready),
        .s_payload  (aw_payload),
        .m1_valid   (tim_aw_valid),
        .m1_ready   (tim_aw_ready),
        .m1_payload (),             // Timing needs only the handshake
        .m2_valid   (dat_aw_valid),
        .m2_ready   (dat_aw_ready),
        .m2_payload (dat_aw_payload)
    );

    rv_fork #(.payload_t(w_t)) u_fork_w (
        .clk        (clk),
        .rst        (rst),
        .s_valid    (w_valid),
        .s_ready    (w_ready),
        .s_payload  (w_payload),
        .m1_valid   (tim_w_valid),
        .m1_ready   (tim_w_ready),
        .m1_payload (tim_w_payload),
        .m2_valid   (dat_w_valid),
        .m2_ready   (dat_w_ready),
        .m2_payload (dat_w_payload)
    );

    rammodel_timing u_timing (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (tim_ar_valid),
        .ar_ready (tim_ar_ready),
        .ar_len   (tim_ar_payload.len),
        .r_valid  (tim_r_valid),
        .r_ready  (r_ready),
        .aw_valid (tim_aw_valid),
        .aw_ready (tim_aw_ready),
        .w_valid  (tim_w_valid),
        .w_ready  (tim_w_ready),
        .w_last   (tim_w_payload.last),
        .b_valid  (tim_b_valid),
        .b_ready  (b_ready),
        .stall    (dut_stall)
    );

    // Response due but data still missing stops the emulated clock
    assign dut_stall = pause
                    || (tim_r_valid && !dat_r_valid)
                    || (tim_b_valid && !dat_b_valid);

    assign r_valid     = tim_r_valid && !dut_stall;
    assign dat_r_ready = tim_r_valid && r_ready && !dut_stall;
    assign b_valid     = tim_b_valid && !dut_stall;
    assign dat_b_ready = tim_b_valid && b_ready && !dut_stall;

    rammodel_txn_gate u_gate (
        .clk          (clk),
        .rst          (rst),
        .s_ar_valid   (dat_ar_valid),
        .s_ar_ready   (dat_ar_ready),
        .s_ar_payload (dat_ar_payload),
        .s_aw_valid   (dat_aw_valid),
        .s_aw_ready   (dat_aw_ready),
        .s_aw_payload (dat_aw_payload),
        .s_w_valid    (dat_w_valid),
        .s_w_ready    (dat_w_ready),
        .s_w_payload  (dat_w_payload),
        .s_r_valid    (dat_r_valid),
        .s_r_ready    (dat_r_ready),
        .s_r_payload  (r_payload),    // Content from data side
        .s_b_valid    (dat_b_valid),
        .s_b_ready    (dat_b_ready),
        .s_b_payload  (b_payload),
        .m_ar_valid   (mem_ar_valid),
        .m_ar_ready   (mem_ar_ready),
        .m_ar_payload (mem_ar_payload),
        .m_aw_valid   (mem_aw_valid),
        .m_aw_ready   (mem_aw_ready),
        .m_aw_payload (mem_aw_payload),
        .m_w_valid    (mem_w_valid),
        .m_w_ready    (mem_w_ready),
        .m_w_payload  (mem_w_payload),
        .m_r_valid    (mem_r_valid),
        .m_r_ready    (mem_r_ready),
        .m_r_payload  (mem_r_payload),
        .m_b_valid    (mem_b_valid),
        .m_b_ready    (mem_b_ready),
        .m_b_payload  (mem_b_payload),
        .up_req       (up_req),
        .down_req     (down_req),
        .up           (up),
        .down         (down)
    );

    // A due response waits for the DUT and is never dropped
    assert property (@(posedge clk) disable iff (rst)
        tim_r_valid && !(r_valid && r_ready) |=> tim_r_valid)
        else $error("rammodel_simple: due R beat dropped before handshake");
    assert property (@(posedge clk) disable iff (rst)
        tim_b_valid && !(b_valid && b_ready) |=> tim_b_valid)
        else $error("rammodel_simple: due B dropped before handshake");

endmodule

`default_nettype wire

// ==== logic/rammodel_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rammodel_defines.svh"

module rammodel_store import rammodel_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ar_valid,
    output logic ar_ready,
    input  ax_t  ar_payload,
    output logic r_valid,
    input  logic r_ready,
    output r_t   r_payload,
    input  logic aw_valid,
    output logic aw_ready,
    input  ax_t  aw_payload,
    input  logic w_valid,
    output logic w_ready,
    input  w_t   w_payload,
    output logic b_valid,
    input  logic b_ready,
    output b_t   b_payload
);
    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [`RAM_DATA_WIDTH-1:0] mem [`RAM_WORDS];
    logic [IDX_W-1:0]           r_addr;    // Next beat to fetch
    logic [`RAM_LEN_WIDTH-1:0]  r_left;
    logic [`RAM_ID_WIDTH-1:0]   r_id;
    logic [`RAM_DATA_WIDTH-1:0] r_data;
    logic                       w_active;
    logic [IDX_W-1:0]           w_addr;
    logic [`RAM_ID_WIDTH-1:0]   b_id;
    logic                       ar_hs;
    logic                       r_hs;
    logic                       w_hs;

    assign ar_hs     = ar_valid && ar_ready;
    assign r_hs      = r_valid && r_ready;
    assign w_hs      = w_valid && w_ready;
    assign ar_ready  = !r_valid;
    assign aw_ready  = !w_active && !b_valid;
    assign w_ready   = w_active;
    assign r_payload = '{id: r_id, data: r_data, last: (r_left == '0)};
    assign b_payload = '{id: b_id};

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid  <= 1'b0;
            w_active <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            if (ar_hs) r_valid <= 1'b1;
            else if (r_hs && r_left == '0) r_valid <= 1'b0;
            if (aw_valid && aw_ready) w_active <= 1'b1;
            else if (w_hs && w_payload.last) w_active <= 1'b0;
            if (w_hs && w_payload.last) b_valid <= 1'b1;
            else if (b_valid && b_ready) b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            r_id   <= ar_payload.id;
            r_left <= ar_payload.len;
            r_data <= mem[ar_payload.addr[IDX_W-1:0]];
            r_addr <= ar_payload.addr[IDX_W-1:0] + 1'b1;    // Wraps at depth
        end else if (r_hs) begin
            r_left <= r_left - 1'b1;
            r_data <= mem[r_addr];
            r_addr <= r_addr + 1'b1;
        end
        if (aw_valid && aw_ready) begin
            w_addr <= aw_payload.addr[IDX_W-1:0];
            b_id   <= aw_payload.id;
        end else if (w_hs) begin
            w_addr <= w_addr + 1'b1;
        end
        if (w_hs) mem[w_addr] <= w_payload.data;
    end

endmodule

`default_nettype wire

// ==== logic/rammodel_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rammodel_defines.svh"

module rammodel_timing (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    input  logic [`RAM_LEN_WIDTH-1:0] ar_len,
    output logic                      r_valid,
    input  logic                      r_ready,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  logic                      w_valid,
    output logic                      w_ready,
    input  logic                      w_last,
    output logic                      b_valid,
    input  logic                      b_ready,
    input  logic                      stall
);
    logic                      r_busy;     // Read outstanding
    logic [3:0]                r_cnt;      // Cycles until first beat due
    logic [`RAM_LEN_WIDTH-1:0] r_beats;    // Beats left after current
    logic                      aw_busy;    // Write outstanding
    logic                      b_wait;     // Last W seen, B pending
    logic [3:0]                b_cnt;

    // Handshakes only count while the emulation clock runs
    assign ar_ready = !r_busy && !stall;
    assign r_valid  = r_busy && (r_cnt == '0);
    assign aw_ready = !aw_busy && !stall;
    assign w_ready  = !b_wait && !stall;
    assign b_valid  = b_wait && (b_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            r_busy  <= 1'b0;
            r_cnt   <= '0;
            r_beats <= '0;
        end else if (!stall) begin
            if (ar_valid && ar_ready) begin
                r_busy  <= 1'b1;
                r_cnt   <= 4'(`RAM_READ_LATENCY - 1);
                r_beats <= ar_len;
            end else if (r_valid && r_ready) begin
                if (r_beats == '0) r_busy <= 1'b0;
                else r_beats <= r_beats - 1'b1;    // Next beat due next cycle
            end else if (r_cnt != '0) begin
                r_cnt <= r_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_busy <= 1'b0;
            b_wait  <= 1'b0;
            b_cnt   <= '0;
        end else if (!stall) begin
            if (aw_valid && aw_ready) aw_busy <= 1'b1;
            if (w_valid && w_ready && w_last) begin
                b_wait <= 1'b1;
                b_cnt  <= 4'(`RAM_WRITE_LATENCY - 1);
            end else if (b_valid && b_ready) begin
                b_wait  <= 1'b0;
                aw_busy <= 1'b0;
            end else if (b_cnt != '0) begin
                b_cnt <= b_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rammodel_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rammodel_top import rammodel_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ar_valid,
    output logic ar_ready,
    input  ax_t  ar_payload,
    input  logic aw_valid,
    output logic aw_ready,
    input  ax_t  aw_payload,
    input  logic w_valid,
    output logic w_ready,
    input  w_t   w_payload,
    output logic r_valid,
    input  logic r_ready,
    output r_t   r_payload,
    output logic b_valid,
    input  logic b_ready,
    output b_t   b_payload,
    input  logic pause,
    input  logic up_req,
    input  logic down_req,
    output logic up,
    output logic down,
    output logic dut_stall
);
    logic mem_ar_valid;
    logic mem_ar_ready;
    ax_t  mem_ar_payload;
    logic mem_aw_valid;
    logic mem_aw_ready;
    ax_t  mem_aw_payload;
    logic mem_w_valid;
    logic mem_w_ready;
    w_t   mem_w_payload;
    logic mem_r_valid;
    logic mem_r_ready;
    r_t   mem_r_payload;
    logic mem_b_valid;
    logic mem_b_ready;
    b_t   mem_b_payload;

    rammodel_simple u_simple (.*);    // Names match one to one

    rammodel_store u_store (
        .clk        (clk),
        .rst        (rst),
        .ar_valid   (mem_ar_valid),
        .ar_ready   (mem_ar_ready),
        .ar_payload (mem_ar_payload),
        .r_valid    (mem_r_valid),
        .r_ready    (mem_r_ready),
        .r_payload  (mem_r_payload),
        .aw_valid   (mem_aw_valid),
        .aw_ready   (mem_aw_ready),
        .aw_payload (mem_aw_payload),
        .w_valid    (mem_w_valid),
        .w_ready    (mem_w_ready),
        .w_payload  (mem_w_payload),
        .b_valid    (mem_b_valid),
        .b_ready    (mem_b_ready),
        .b_payload  (mem_b_payload)
    );

endmodule

`default_nettype wire

// ==== logic/rammodel_txn_gate.sv ====
`timescale 1ns/1ns
`default_nettype none

module rammodel_txn_gate import rammodel_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic s_ar_valid,
    output logic s_ar_ready,
    input  ax_t  s_ar_payload,
    input  logic s_aw_valid,
    output logic s_aw_ready,
    input  ax_t  s_aw_payload,
    input  logic s_w_valid,
    output logic s_w_ready,
    input  w_t   s_w_payload,
    output logic s_r_valid,
    input  logic s_r_ready,
    output r_t   s_r_payload,
    output logic s_b_valid,
    input  logic s_b_ready,
    output b_t   s_b_payload,
    output logic m_ar_valid,
    input  logic m_ar_ready,
    output ax_t  m_ar_payload,
    output logic m_aw_valid,
    input  logic m_aw_ready,
    output ax_t  m_aw_payload,
    output logic m_w_valid,
    input  logic m_w_ready,
    output w_t   m_w_payload,
    input  logic m_r_valid,
    output logic m_r_ready,
    input  r_t   m_r_payload,
    input  logic m_b_valid,
    output logic m_b_ready,
    input  b_t   m_b_payload,
    input  logic up_req,
    input  logic down_req,
    output logic up,
    output logic down
);
    gate_state_t state;
    logic [2:0]  rd_cnt;    // Read bursts awaiting last R
    logic [2:0]  wr_cnt;    // Write bursts awaiting B
    logic        pass;
    logic        accept;

    assign pass   = (state != DOWN);
    assign accept = (state == UP);    // No new bursts while draining
    assign up     = (state == UP);
    assign down   = (state == DOWN);

    assign m_ar_valid   = s_ar_valid && accept;
    assign s_ar_ready   = m_ar_ready && accept;
    assign m_aw_valid   = s_aw_valid && accept;
    assign s_aw_ready   = m_aw_ready && accept;
    assign m_w_valid    = s_w_valid && pass;
    assign s_w_ready    = m_w_ready && pass;
    assign s_r_valid    = m_r_valid && pass;
    assign m_r_ready    = s_r_ready && pass;
    assign s_b_valid    = m_b_valid && pass;
    assign m_b_ready    = s_b_ready && pass;
    assign m_ar_payload = s_ar_payload;
    assign m_aw_payload = s_aw_payload;
    assign m_w_payload  = s_w_payload;
    assign s_r_payload  = m_r_payload;
    assign s_b_payload  = m_b_payload;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= UP;
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else begin
            rd_cnt <= rd_cnt + 3'(m_ar_valid && m_ar_ready)
                    - 3'(m_r_valid && m_r_ready && m_r_payload.last);
            wr_cnt <= wr_cnt + 3'(m_aw_valid && m_aw_ready) - 3'(m_b_valid && m_b_ready);
            case (state)
                UP:      if (down_req && !up_req) state <= DRAIN;
                DRAIN:   if (rd_cnt == '0 && wr_cnt == '0) state <= DOWN;
                DOWN:    if (up_req && !down_req) state <= UP;
                default: state <= UP;
            endcase
        end
    end

    // Drain leaves the store idle before the gate closes
    assert property (@(posedge clk) disable iff (rst) down |-> !m_r_valid && !m_b_valid)
        else $error("rammodel_txn_gate: response pending while down");

endmodule

`default_nettype wire

// ==== logic/rv_fork.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_fork #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     s_valid,
    output logic     s_ready,
    input  payload_t s_payload,
    output logic     m1_valid,
    input  logic     m1_ready,
    output payload_t m1_payload,
    output logic     m2_valid,
    input  logic     m2_ready,
    output payload_t m2_payload
);
    logic taken1;    // Branch already holds this payload
    logic taken2;

    assign m1_valid   = s_valid && !taken1;
    assign m2_valid   = s_valid && !taken2;
    assign m1_payload = s_payload;
    assign m2_payload = s_payload;
    assign s_ready    = (taken1 || m1_ready) && (taken2 || m2_ready);

    always_ff @(posedge clk) begin
        if (rst || (s_valid && s_ready)) begin
            taken1 <= 1'b0;
            taken2 <= 1'b0;
        end else begin
            if (m1_valid && m1_ready) taken1 <= 1'b1;
            if (m2_valid && m2_ready) taken2 <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        s_valid && !s_ready |=> $stable(s_payload))
        else $error("rv_fork: payload changed before handshake");

endmodule

`default_nettype wire

// ==== rammodel.f ====
+incdir+include
logic/rammodel_pkg.sv
logic/rv_fork.sv
logic/rammodel_timing.sv
logic/rammodel_txn_gate.sv
logic/rammodel_store.sv
logic/rammodel_simple.sv
logic/rammodel_top.sv
sim/tb_rammodel.sv

// ==== sim/rammodel_trace.txt ====
# op id addr len seed (all hex, len is beats minus one)
# W: beat k writes seed+k. R: seed is r_ready low cycles. P: seed is pause cycles. G: seed unused
W 1 10 0 a5a50001
R 1 10 0 0
W 2 20 0 12345678
R 3 20 0 0
W 4 40 3 c0de0000
R 5 40 3 0
W 6 80 f 0bad0100
R 7 80 f 0
R 8 82 3 5
W 9 fe 3 77770000
R a fe 3 2
W b fc f deadbe00
R c fc f 4
P d 40 3 c
W e 30 0 13572468
P f 30 0 9
G 2 80 3 0
R 3 86 1 3
G 4 fc 7 0
R 5 00 0 0

// ==== sim/tb_rammodel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rammodel_defines.svh"

module tb_rammodel import rammodel_pkg::*; ();
    logic clk;
    logic rst;
    logic ar_valid;
    logic ar_ready;
    ax_t  ar_payload;
    logic aw_valid;
    logic aw_ready;
    ax_t  aw_payload;
    logic w_valid;
    logic w_ready;
    w_t   w_payload;
    logic r_valid;
    logic r_ready;
    r_t   r_payload;
    logic b_valid;
    logic b_ready;
    b_t   b_payload;
    logic pause;
    logic up_req;
    logic down_req;
    logic up;
    logic down;
    logic dut_stall;

    logic [`RAM_DATA_WIDTH-1:0] shadow [`RAM_WORDS];    // Expected memory contents
    int          cycles = 0;
    int          cycle_limit = 0;    // Zero until the trace is loaded
    logic [7:0]  op_list [$];
    logic [3:0]  id_list [$];
    logic [7:0]  addr_list [$];
    logic [3:0]  len_list [$];
    logic [31:0] seed_list [$];

    rammodel_top DUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
            stop_with_failure($sformatf("Simulation timed out after %0d cycles", cycles));
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic expect_equal(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (actual !== expected)
            stop_with_failure($sformatf("Error: %s expected %0h actual %0h",
                                        what, expected, actual));
    endtask

    // Called at the sample point of the AR handshake cycle
    task automatic receive_beats(input logic [3:0] req_id, input logic [7:0] req_addr,
                                 input logic [3:0] req_len, input bit timed,
                                 input int ar_edge, input int hold);
        int k;
        r_t held;
        k = 0;
        while (k <= req_len) begin
            @(negedge clk);
            ar_valid = 1'b0;
            pause    = 1'b0;
            r_ready  = 1'b1;
            #1;
            expect_equal("stall during read", 0, dut_stall);
            if (r_valid) begin
                if (k == 0 && timed)
                    expect_equal("read latency", `RAM_READ_LATENCY, cycles - ar_edge);
                expect_equal("read id", req_id, r_payload.id);
                expect_equal("read data", shadow[(int'(req_addr) + k) % `RAM_WORDS],
                             r_payload.data);
                expect_equal("read last", k == req_len, r_payload.last);
                k++;
                if (k == 1 && req_len > 0 && hold > 0) begin
                    @(negedge clk);
                    r_ready = 1'b0;    // Back-pressure on the second beat
                    #1;
                    held = r_payload;
                    repeat (hold) begin
                        @(negedge clk);
                        #1;
                        expect_equal("r valid under back-pressure", 1, r_valid);
                        expect_equal("r payload under back-pressure", held, r_payload);
                    end
                end
            end
        end
        @(negedge clk);
        #1;
        expect_equal("no extra r beat", 0, r_valid);
    endtask

    task automatic write_burst(input logic [3:0] req_id, input logic [7:0] req_addr,
                               input logic [3:0] req_len, input logic [31:0] seed);
        int k;
        b_t held;
        @(negedge clk);
        aw_valid        = 1'b1;
        aw_payload.id   = req_id;
        aw_payload.addr = req_addr;
        aw_payload.len  = req_len;
        b_ready         = 1'b0;
        #1;
        while (!aw_ready) begin
            @(negedge clk);
            #1;
        end
        for (k = 0; k <= req_len; k++) begin
            @(negedge clk);
            aw_valid       = 1'b0;
            w_valid        = 1'b1;
            w_payload.data = seed + 32'(k);
            w_payload.last = (k == req_len);
            #1;
            if (k == 0)
                expect_equal("aw ready while write open", 0, aw_ready);
            while (!w_ready) begin
                @(negedge clk);
                #1;
            end
            shadow[(int'(req_addr) + k) % `RAM_WORDS] = seed + 32'(k);
        end
        @(negedge clk);
        w_valid = 1'b0;
        #1;
        expect_equal("w ready after last beat", 0, w_ready);
        while (!b_valid) begin
            expect_equal("stall during write", 0, dut_stall);
            @(negedge clk);
            #1;
        end
        held = b_payload;
        repeat (3) begin
            @(negedge clk);
            #1;
            expect_equal("b valid under back-pressure", 1, b_valid);
            expect_equal("b payload under back-pressure", held, b_payload);
        end
        @(negedge clk);
        b_ready = 1'b1;
        #1;
        expect_equal("write id", req_id, b_payload.id);
        @(negedge clk);
        b_ready = 1'b0;
        #1;
        expect_equal("no extra b", 0, b_valid);
    endtask

    // Plain read when paused is 0, else pause held for extra cycles after AR
    task automatic read_burst(input logic [3:0] req_id, input logic [7:0] req_addr,
                              input logic [3:0] req_len, input int extra, input bit paused);
        int ar_edge;
        @(negedge clk);
        ar_valid        = 1'b1;
        ar_payload.id   = req_id;
        ar_payload.addr = req_addr;
        ar_payload.len  = req_len;
        r_ready         = 1'b1;
        #1;
        while (!ar_ready) begin
            @(negedge clk);
            #1;
        end
        ar_edge = cycles;
        if (paused) begin
            repeat (extra) begin
                @(negedge clk);
                ar_valid = 1'b0;
                pause    = 1'b1;
                #1;
                expect_equal("stall while paused", 1, dut_stall);
                expect_equal("r valid while paused", 0, r_valid);
                expect_equal("b valid while paused", 0, b_valid);
            end
            receive_beats(req_id, req_addr, req_len, 1'b0, ar_edge, 0);
        end else begin
            receive_beats(req_id, req_addr, req_len, 1'b1, ar_edge, extra);
        end
    endtask

    task automatic gate_cycle(input logic [3:0] req_id, input logic [7:0] req_addr,
                              input logic [3:0] req_len);
        int ar_edge;
        @(negedge clk);
        down_req = 1'b1;
        #1;
        while (!down) begin
            @(negedge clk);
            #1;
        end
        expect_equal("up while down", 0, up);
        @(negedge clk);
        down_req        = 1'b0;
        ar_valid        = 1'b1;
        ar_payload.id   = req_id;
        ar_payload.addr = req_addr;
        ar_payload.len  = req_len;
        r_ready         = 1'b1;
        #1;
        while (!dut_stall) begin    // Timing model still counting
            expect_equal("ar ready while down", 0, ar_ready);
            expect_equal("down after down_req falls", 1, down);
            @(negedge clk);
            #1;
        end
        repeat (8) begin
            @(negedge clk);
            #1;
            expect_equal("stall while down", 1, dut_stall);
            expect_equal("r valid while down", 0, r_valid);
            expect_equal("ar ready while down", 0, ar_ready);
        end
        @(negedge clk);
        up_req = 1'b1;
        #1;
        while (!ar_ready) begin
            @(negedge clk);
            #1;
        end
        expect_equal("up after up_req", 1, up);
        expect_equal("down after up_req", 0, down);
        ar_edge = cycles;
        receive_beats(req_id, req_addr, req_len, 1'b0, ar_edge, 0);
        @(negedge clk);
        up_req = 1'b0;
        #1;
        expect_equal("up after up_req falls", 1, up);
        expect_equal("stall after gate up", 0, dut_stall);
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  op;
        logic [3:0]  t_id;
        logic [7:0]  t_addr;
        logic [3:0]  t_len;
        logic [31:0] t_seed;
        rst        = 1'b1;
        ar_valid   = 1'b0;
        ar_payload = '0;
        aw_valid   = 1'b0;
        aw_payload = '0;
        w_valid    = 1'b0;
        w_payload  = '0;
        r_ready    = 1'b0;
        b_ready    = 1'b0;
        pause      = 1'b0;
        up_req     = 1'b0;
        down_req   = 1'b0;
        fd = $fopen("sim/rammodel_trace.txt", "r");
        if (fd == 0)
            stop_with_failure("Could not open the trace file sim/rammodel_trace.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%c %h %h %h %h", op, t_id, t_addr, t_len, t_seed);
                if (fields != 5)
                    stop_with_failure({"Trace line could not be parsed: ", line});
                op_list.push_back(op);
                id_list.push_back(t_id);
                addr_list.push_back(t_addr);
                len_list.push_back(t_len);
                seed_list.push_back(t_seed);
            end
        end
        $fclose(fd);
        cycle_limit = op_list.size() * (16 + `RAM_READ_LATENCY + 40);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        expect_equal("up after reset", 1, up);
        expect_equal("down after reset", 0, down);
        expect_equal("stall after reset", 0, dut_stall);
        foreach (op_list[i]) begin
            case (op_list[i])
                "W": write_burst(id_list[i], addr_list[i], len_list[i], seed_list[i]);
                "R": read_burst(id_list[i], addr_list[i], len_list[i], seed_list[i], 1'b0);
                "P": read_burst(id_list[i], addr_list[i], len_list[i], seed_list[i], 1'b1);
                "G": gate_cycle(id_list[i], addr_list[i], len_list[i]);
                default: stop_with_failure($sformatf("Unknown operation in trace line %0d", i));
            endcase
        end
        expect_equal("up at end", 1, up);
        expect_equal("stall at end", 0, dut_stall);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
